// File: flist.f
logic/rv_isa_pkg.sv
logic/core_ctrl_pkg.sv
logic/inst_decoder.sv
logic/reg_file.sv
logic/alu.sv
logic/core.sv
logic/data_ram.sv
logic/rv_system.sv
testbench/tb_rv_system.sv

// File: Bender.yml
package:
  name: rv_system

sources:
  - files:
      - logic/rv_isa_pkg.sv
      - logic/core_ctrl_pkg.sv
      - logic/inst_decoder.sv
      - logic/reg_file.sv
      - logic/alu.sv
      - logic/core.sv
      - logic/data_ram.sv
      - logic/rv_system.sv
  - target: test
    files:
      - testbench/tb_rv_system.sv

// File: testbench/tb_rv_system.sv
module tb_rv_system;
    import rv_isa_pkg::*;
    import core_ctrl_pkg::*;

    localparam int              prog_len    = 100;
    localparam int              rst_cycles  = 10;
    localparam int              cycle_limit = 2 * prog_len + rst_cycles;
    localparam logic [xlen-1:0] exit_pc     = (prog_len - 1) * 4; // last program word
    localparam logic [xlen-1:0] nop         = 32'h0000_0013;

    typedef struct packed {
        logic                  rd_wen;
        logic [reg_addr_w-1:0] rd_addr;
        logic [xlen-1:0]       rd_data;
        logic                  st_wen;
        logic [xlen-1:0]       st_addr;
        logic [xlen-1:0]       st_wdata;
        logic                  chk_op;
        alu_op_e               op;
        logic [xlen-1:0]       next_pc;
    } trace_t;

    logic                  clk;
    logic                  rst_n;
    logic [xlen-1:0]       imem_addr, imem_inst, retire_pc, rd_data, st_addr, st_wdata;
    logic                  retire, rd_wen, st_wen, halt;
    logic [reg_addr_w-1:0] rd_addr;

    logic [xlen-1:0] rom [prog_len];
    logic [xlen-1:0] model_regs [32];
    logic [xlen-1:0] model_mem [256];
    logic [xlen-1:0] model_pc;
    integer          seed;
    int              n_words;
    int              cycles = 0;

    rv_system #(.exit_addr(exit_pc), .dmem_words(256)) UUT (
        .clk(clk), .rst_n(rst_n), .imem_addr_o(imem_addr), .imem_inst_i(imem_inst),
        .retire_o(retire), .retire_pc_o(retire_pc), .rd_wen_o(rd_wen), .rd_addr_o(rd_addr),
        .rd_data_o(rd_data), .st_wen_o(st_wen), .st_addr_o(st_addr), .st_wdata_o(st_wdata),
        .halt_o(halt)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, op_reg};
    endfunction

    function automatic logic [31:0] enc_i(opcode_e opc, logic [11:0] imm, logic [4:0] rs1,
                                          logic [2:0] f3, logic [4:0] rd);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, f3_word, imm[4:0], op_store};
    endfunction

    function automatic logic [31:0] enc_b(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                          logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], op_branch};
    endfunction

    function automatic logic [31:0] enc_j(logic [4:0] rd, logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, op_jal};
    endfunction

    function automatic logic [xlen-1:0] fetch(input logic [xlen-1:0] addr);
        if (addr < prog_len * 4) return rom[addr[31:2]];
        return nop;
    endfunction

    task automatic abort_run();
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic emit(input logic [31:0] w);
        rom[n_words] = w;
        n_words++;
    endtask

    task automatic emit_branch(input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2);
        emit(enc_b(f3, rs1, rs2, 13'd8));
        emit(enc_i(op_imm, 12'd1, 5'd9, f3_add_sub, 5'd9)); // skipped when taken
    endtask

    task automatic build_program();
        logic [31:0] r;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        logic        alt;
        for (int i = 0; i < prog_len; i++) begin
            rom[i] = nop;
        end
        n_words = 0;
        emit(enc_i(op_imm, -12'sd5, 5'd0, f3_add_sub, 5'd1));
        emit(enc_i(op_imm, 12'd7, 5'd0, f3_add_sub, 5'd2));
        emit(enc_i(op_imm, -12'sd5, 5'd0, f3_add_sub, 5'd3));
        emit(enc_i(op_imm, -12'sd29, 5'd0, f3_add_sub, 5'd11)); // shamt 3, upper bits set
        emit(enc_i(op_imm, 12'h7ff, 5'd0, f3_add_sub, 5'd4));
        emit(enc_i(op_imm, 12'd20, 5'd4, f3_sll, 5'd4));
        emit(enc_r(7'd0, 5'd2, 5'd1, f3_sll, 5'd5));
        emit(enc_r(7'd0, 5'd2, 5'd1, f3_srl_sra, 5'd6));
        emit(enc_r(f7_alt, 5'd2, 5'd1, f3_srl_sra, 5'd7));
        emit(enc_r(f7_alt, 5'd11, 5'd1, f3_srl_sra, 5'd8));
        emit(enc_r(7'd0, 5'd11, 5'd4, f3_sll, 5'd8));
        emit(enc_i(op_imm, 12'd4, 5'd1, f3_srl_sra, 5'd9));
        emit(enc_i(op_imm, {f7_alt, 5'd4}, 5'd1, f3_srl_sra, 5'd10));
        emit(enc_r(7'd0, 5'd2, 5'd1, f3_slt, 5'd13));
        emit(enc_r(7'd0, 5'd2, 5'd1, f3_sltu, 5'd13));
        emit(enc_i(op_imm, -12'sd6, 5'd1, f3_slt, 5'd14));
        emit(enc_i(op_imm, -12'sd1, 5'd2, f3_sltu, 5'd14));
        emit(enc_i(op_imm, 12'd64, 5'd0, f3_add_sub, 5'd5));
        emit(enc_s(-12'sd4, 5'd1, 5'd5));
        emit(enc_s(12'd20, 5'd4, 5'd0));
        emit(enc_i(op_load, -12'sd4, 5'd5, f3_word, 5'd15));
        emit(enc_i(op_load, 12'd20, 5'd0, f3_word, 5'd14));
        emit(enc_i(op_imm, 12'd9, 5'd1, f3_add_sub, 5'd0)); // x0 target
        emit(enc_r(7'd0, 5'd0, 5'd0, f3_add_sub, 5'd6));
        emit(32'h0000_52b7); // lui is not decoded
        // x1 = x3 = -5, x2 = 7
        emit_branch(f3_beq, 5'd1, 5'd3);
        emit_branch(f3_beq, 5'd1, 5'd2);
        emit_branch(f3_bne, 5'd1, 5'd2);
        emit_branch(f3_bne, 5'd1, 5'd3);
        emit_branch(f3_blt, 5'd1, 5'd2);
        emit_branch(f3_blt, 5'd2, 5'd1);
        emit_branch(f3_bge, 5'd1, 5'd3);
        emit_branch(f3_bge, 5'd1, 5'd2);
        emit_branch(f3_bltu, 5'd2, 5'd1);
        emit_branch(f3_bltu, 5'd1, 5'd2);
        emit_branch(f3_bgeu, 5'd1, 5'd2);
        emit_branch(f3_bgeu, 5'd2, 5'd1);
        emit(enc_j(5'd10, 21'd8));
        emit(enc_i(op_imm, 12'd1, 5'd9, f3_add_sub, 5'd9));
        emit(enc_i(op_imm, 12'((n_words + 3) * 4), 5'd0, f3_add_sub, 5'd12));
        emit(enc_i(op_jalr, 12'd1, 5'd12, f3_jalr, 5'd11)); // odd target
        emit(enc_i(op_imm, 12'd1, 5'd9, f3_add_sub, 5'd9));
        for (int k = 0; k < 40; k++) begin
            r   = $random(seed);
            f3  = r[18:16];
            alt = r[20];
            if (r[19]) begin
                if (f3 == f3_sll) imm = {7'd0, r[25:21]};
                else if (f3 == f3_srl_sra) imm = {alt ? f7_alt : 7'd0, r[25:21]};
                else imm = {{6{r[31]}}, r[31:26]};
                emit(enc_i(op_imm, imm, 5'(1 + r[11:8] % 15), f3, 5'(1 + r[7:4] % 15)));
            end else begin
                f7 = (alt && (f3 == f3_add_sub || f3 == f3_srl_sra)) ? f7_alt : 7'd0;
                emit(enc_r(f7, 5'(1 + r[15:12] % 15), 5'(1 + r[11:8] % 15), f3,
                           5'(1 + r[7:4] % 15)));
            end
        end
        if (n_words > prog_len - 1) begin
            $display("program does not fit below the exit address");
            abort_run();
        end
    endtask

    function automatic logic [xlen-1:0] alu_calc(input logic [2:0] f3, input logic alt,
            input logic [xlen-1:0] a, input logic [xlen-1:0] b, output alu_op_e op);
        logic [xlen-1:0] sra_v;
        sra_v = (a >> b[4:0]) | (~({xlen{1'b1}} >> b[4:0]) & {xlen{a[31]}}); // sign fill
        case (f3)
            f3_add_sub: op = alt ? alu_sub : alu_add;
            f3_sll:     op = alu_sll;
            f3_slt:     op = alu_slt;
            f3_sltu:    op = alu_sltu;
            f3_xor:     op = alu_xor;
            f3_srl_sra: op = alt ? alu_sra : alu_srl;
            f3_or:      op = alu_or;
            default:    op = alu_and;
        endcase
        case (f3)
            f3_add_sub: return alt ? a - b : a + b;
            f3_sll:     return a << b[4:0];
            f3_slt:     return {31'd0, $signed(a) < $signed(b)};
            f3_sltu:    return {31'd0, a < b};
            f3_xor:     return a ^ b;
            f3_srl_sra: return alt ? sra_v : a >> b[4:0];
            f3_or:      return a | b;
            default:    return a & b;
        endcase
    endfunction

    function automatic trace_t ref_step(input logic [xlen-1:0] inst, input logic [xlen-1:0] pc);
        trace_t          t;
        opcode_e         opc;
        alu_op_e         op;
        logic [2:0]      f3;
        logic [xlen-1:0] a, b, imm_i, imm_s, imm_b, imm_j, ea;
        logic            take;
        opc   = opcode_e'(inst[6:0]);
        f3    = inst[14:12];
        a     = model_regs[inst[19:15]];
        b     = model_regs[inst[24:20]];
        imm_i = {{20{inst[31]}}, inst[31:20]};
        imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
        imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
        op    = alu_add;
        t         = '0;
        t.rd_addr = inst[11:7];
        t.next_pc = pc + 4;
        case (opc)
            op_reg, op_imm: begin
                t.rd_wen = 1'b1;
                t.chk_op = 1'b1;
                if (opc == op_reg) t.rd_data = alu_calc(f3, inst[30], a, b, op);
                else t.rd_data = alu_calc(f3, inst[30] && f3 == f3_srl_sra, a, imm_i, op);
            end
            op_load: begin
                ea        = a + imm_i;
                t.rd_wen  = 1'b1;
                t.rd_data = model_mem[ea[9:2]];
            end
            op_store: begin
                t.st_wen   = 1'b1;
                t.st_addr  = a + imm_s;
                t.st_wdata = b;
            end
            op_branch: begin
                case (f3)
                    f3_beq:  take = (a == b);
                    f3_bne:  take = (a != b);
                    f3_blt:  take = $signed(a) < $signed(b);
                    f3_bge:  take = $signed(a) >= $signed(b);
                    f3_bltu: take = a < b;
                    f3_bgeu: take = a >= b;
                    default: take = 1'b0;
                endcase
                if (take) t.next_pc = pc + imm_b;
            end
            op_jal, op_jalr: begin
                t.rd_wen  = 1'b1;
                t.rd_data = pc + 4;
                ea        = a + imm_i;
                t.next_pc = (opc == op_jal) ? pc + imm_j : {ea[xlen-1:1], 1'b0};
            end
            default: ;
        endcase
        t.op = op;
        return t;
    endfunction

    task automatic check_word(input string name, input logic [xlen-1:0] got,
                              input logic [xlen-1:0] exp);
        if (got !== exp) begin
            $display("ERR %0t %s exp=%h got=%h", $time, name, exp, got);
            abort_run();
        end
    endtask

    task automatic check_reg_addr(input string name, input logic [reg_addr_w-1:0] got,
                                  input logic [reg_addr_w-1:0] exp);
        if (got !== exp) begin
            $display("ERR %0t %s exp=x%0d got=x%0d", $time, name, exp, got);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %0t %s exp=%b got=%b", $time, name, exp, got);
            abort_run();
        end
    endtask

    task automatic check_alu_op(input string name, input alu_op_e got, input alu_op_e exp);
        if (got !== exp) begin
            $display("ERR %0t %s exp=%s got=%s", $time, name, exp.name(), got.name());
            abort_run();
        end
    endtask

    // instruction rom model
    always @(negedge clk) begin
        imem_inst <= fetch(imem_addr);
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("halt never reached within %0d cycles", cycle_limit);
            abort_run();
        end
    end

    initial begin
        trace_t t;
        clk       = 1'b0;
        rst_n     = 1'b0;
        imem_inst = nop;
        seed      = 32'hc3a95361;
        model_pc  = '0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < 256; i++) begin
            model_mem[i] = '0;
        end
        build_program();
        repeat (rst_cycles) @(negedge clk);
        rst_n = 1'b1;
        while (model_pc != exit_pc) begin
            #1; // rom word settled
            check_bit("halt_o", halt, 1'b0);
            check_bit("retire_o", retire, 1'b1);
            check_word("retire_pc_o", retire_pc, model_pc);
            t = ref_step(fetch(model_pc), model_pc);
            check_bit("rd_wen_o", rd_wen, t.rd_wen);
            check_bit("st_wen_o", st_wen, t.st_wen);
            if (t.rd_wen) begin
                check_reg_addr("rd_addr_o", rd_addr, t.rd_addr);
                check_word("rd_data_o", rd_data, t.rd_data);
            end
            if (t.st_wen) begin
                check_word("st_addr_o", st_addr, t.st_addr);
                check_word("st_wdata_o", st_wdata, t.st_wdata);
            end
            if (t.chk_op) check_alu_op("alu_op", UUT.u_core.alu_op, t.op);
            if (t.rd_wen && t.rd_addr != '0) model_regs[t.rd_addr] = t.rd_data;
            if (t.st_wen) model_mem[t.st_addr[9:2]] = t.st_wdata;
            model_pc = t.next_pc;
            @(negedge clk);
        end
        // exit word alternates between a nop and a sw while halted
        for (int k = 0; k < 4; k++) begin
            #1;
            check_bit("halt_o", halt, 1'b1);
            check_bit("retire_o", retire, 1'b0);
            check_bit("rd_wen_o", rd_wen, 1'b0);
            check_bit("st_wen_o", st_wen, 1'b0);
            check_word("imem_addr_o", imem_addr, exit_pc);
            check_word("retire_pc_o", retire_pc, exit_pc);
            if (k % 2 == 0) rom[prog_len - 1] = enc_s(12'd0, 5'd1, 5'd0);
            else rom[prog_len - 1] = nop;
            @(negedge clk);
        end
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// File: logic/rv_system.sv
module rv_system #(
    parameter logic [rv_isa_pkg::xlen-1:0] exit_addr  = 8,
    parameter int unsigned                 dmem_words = 256
) (
    input  logic                              clk,
    input  logic                              rst_n,
    output logic [rv_isa_pkg::xlen-1:0]       imem_addr_o,
    input  logic [rv_isa_pkg::xlen-1:0]       imem_inst_i,
    output logic                              retire_o,
    output logic [rv_isa_pkg::xlen-1:0]       retire_pc_o,
    output logic                              rd_wen_o,
    output logic [rv_isa_pkg::reg_addr_w-1:0] rd_addr_o,
    output logic [rv_isa_pkg::xlen-1:0]       rd_data_o,
    output logic                              st_wen_o,
    output logic [rv_isa_pkg::xlen-1:0]       st_addr_o,
    output logic [rv_isa_pkg::xlen-1:0]       st_wdata_o,
    output logic                              halt_o
);
    import rv_isa_pkg::*;

    logic [xlen-1:0] dmem_addr, dmem_wdata, dmem_rdata;
    logic            dmem_wen;

    core #(.exit_addr(exit_addr)) u_core (
        .clk(clk), .rst_n(rst_n), .imem_addr_o(imem_addr_o), .imem_inst_i(imem_inst_i),
        .dmem_addr_o(dmem_addr), .dmem_wen_o(dmem_wen), .dmem_wdata_o(dmem_wdata),
        .dmem_rdata_i(dmem_rdata), .retire_o(retire_o), .retire_pc_o(retire_pc_o),
        .rd_wen_o(rd_wen_o), .rd_addr_o(rd_addr_o), .rd_data_o(rd_data_o), .halt_o(halt_o)
    );

    data_ram #(.dmem_words(dmem_words)) u_dram (
        .clk(clk), .rst_n(rst_n), .addr_i(dmem_addr), .wen_i(dmem_wen),
        .wdata_i(dmem_wdata), .rdata_o(dmem_rdata)
    );

    // store port mirrors the data memory write side
    assign st_wen_o   = dmem_wen;
    assign st_addr_o  = dmem_addr;
    assign st_wdata_o = dmem_wdata;

endmodule

// File: logic/data_ram.sv
module data_ram #(
    parameter int unsigned dmem_words = 256
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [rv_isa_pkg::xlen-1:0] addr_i,
    input  logic                        wen_i,
    input  logic [rv_isa_pkg::xlen-1:0] wdata_i,
    output logic [rv_isa_pkg::xlen-1:0] rdata_o
);
    import rv_isa_pkg::*;

    localparam int idx_w = $clog2(dmem_words);

    logic [xlen-1:0]  mem [dmem_words];
    logic [idx_w-1:0] idx;

    assign idx     = addr_i[idx_w+1:2]; // wraps, depth is a power of two
    assign rdata_o = mem[idx];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < dmem_words; i++) begin
                mem[i] <= '0;
            end
        end else if (wen_i) begin
            mem[idx] <= wdata_i;
        end
    end

    // sw needs a word-aligned address
    store_aligned: assert property (
        @(posedge clk) disable iff (!rst_n) wen_i |-> addr_i[1:0] == 2'b00
    );

endmodule

// File: logic/core.sv
module core #(
    parameter logic [rv_isa_pkg::xlen-1:0] exit_addr = 8
) (
    input  logic                              clk,
    input  logic                              rst_n,
    output logic [rv_isa_pkg::xlen-1:0]       imem_addr_o,
    input  logic [rv_isa_pkg::xlen-1:0]       imem_inst_i,
    output logic [rv_isa_pkg::xlen-1:0]       dmem_addr_o,
    output logic                              dmem_wen_o,
    output logic [rv_isa_pkg::xlen-1:0]       dmem_wdata_o,
    input  logic [rv_isa_pkg::xlen-1:0]       dmem_rdata_i,
    output logic                              retire_o,
    output logic [rv_isa_pkg::xlen-1:0]       retire_pc_o,
    output logic                              rd_wen_o,
    output logic [rv_isa_pkg::reg_addr_w-1:0] rd_addr_o,
    output logic [rv_isa_pkg::xlen-1:0]       rd_data_o,
    output logic                              halt_o
);
    import rv_isa_pkg::*;
    import core_ctrl_pkg::*;

    logic [xlen-1:0]       pc_q, pc_next, pc_plus4;
    logic [reg_addr_w-1:0] rs1_addr, rs2_addr, rd_addr;
    logic [xlen-1:0]       rs1_data, rs2_data, imm;
    logic [xlen-1:0]       op1, op2, alu_result, wb_data;
    alu_op_e               alu_op;
    br_cond_e              br_cond;
    op1_sel_e              op1_sel;
    op2_sel_e              op2_sel;
    wb_sel_e               wb_sel;
    logic                  rf_wen, mem_wen, is_jal, is_jalr, branch_taken;
    logic                  halt;

    inst_decoder u_dec (
        .inst_i(imem_inst_i), .rs1_addr_o(rs1_addr), .rs2_addr_o(rs2_addr),
        .rd_addr_o(rd_addr), .imm_o(imm), .alu_op_o(alu_op), .br_cond_o(br_cond),
        .op1_sel_o(op1_sel), .op2_sel_o(op2_sel), .wb_sel_o(wb_sel), .rf_wen_o(rf_wen),
        .mem_wen_o(mem_wen), .is_jal_o(is_jal), .is_jalr_o(is_jalr)
    );

    reg_file u_rf (
        .clk(clk), .rst_n(rst_n), .rs1_addr_i(rs1_addr), .rs2_addr_i(rs2_addr),
        .rs1_data_o(rs1_data), .rs2_data_o(rs2_data), .wen_i(rd_wen_o),
        .rd_addr_i(rd_addr), .rd_data_i(wb_data)
    );

    alu u_alu (
        .op_i(alu_op), .cond_i(br_cond), .a_i(op1), .b_i(op2),
        .result_o(alu_result), .branch_taken_o(branch_taken)
    );

    assign halt     = (pc_q == exit_addr);
    assign pc_plus4 = pc_q + 32'd4;
    assign op1      = (op1_sel == op1_pc) ? pc_q : rs1_data;
    assign op2      = (op2_sel == op2_imm) ? imm : rs2_data;

    always_comb begin
        if (is_jal)            pc_next = alu_result;
        else if (is_jalr)      pc_next = {alu_result[xlen-1:1], 1'b0};
        else if (branch_taken) pc_next = pc_q + imm;
        else                   pc_next = pc_plus4;
    end

    always_comb begin
        case (wb_sel)
            wb_mem:      wb_data = dmem_rdata_i;
            wb_pc_plus4: wb_data = pc_plus4; // link
            default:     wb_data = alu_result;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) pc_q <= '0;
        else if (!halt) pc_q <= pc_next; // frozen at exit_addr
    end

    assign imem_addr_o  = pc_q;
    assign dmem_addr_o  = alu_result;
    assign dmem_wdata_o = rs2_data;
    assign dmem_wen_o   = mem_wen && !halt;
    assign retire_o     = !halt;
    assign retire_pc_o  = pc_q;
    assign rd_wen_o     = rf_wen && !halt;
    assign rd_addr_o    = rd_addr;
    assign rd_data_o    = wb_data;
    assign halt_o       = halt;

    halt_sticky: assert property (@(posedge clk) disable iff (!rst_n) halt_o |=> halt_o);
    pc_aligned: assert property (@(posedge clk) disable iff (!rst_n) pc_q[1:0] == 2'b00);

endmodule

// File: logic/alu.sv
module alu (
    input  core_ctrl_pkg::alu_op_e      op_i,
    input  core_ctrl_pkg::br_cond_e     cond_i,
    input  logic [rv_isa_pkg::xlen-1:0] a_i,
    input  logic [rv_isa_pkg::xlen-1:0] b_i,
    output logic [rv_isa_pkg::xlen-1:0] result_o,
    output logic                        branch_taken_o
);
    import core_ctrl_pkg::*;

    logic       lt_s;
    logic       lt_u;
    logic       eq;
    logic [4:0] shamt;

    assign lt_s  = $signed(a_i) < $signed(b_i);
    assign lt_u  = a_i < b_i;
    assign eq    = (a_i == b_i);
    assign shamt = b_i[4:0]; // upper bits ignored

    always_comb begin
        case (op_i)
            alu_add:  result_o = a_i + b_i;
            alu_sub:  result_o = a_i - b_i;
            alu_and:  result_o = a_i & b_i;
            alu_or:   result_o = a_i | b_i;
            alu_xor:  result_o = a_i ^ b_i;
            alu_sll:  result_o = a_i << shamt;
            alu_srl:  result_o = a_i >> shamt;
            alu_sra:  result_o = $unsigned($signed(a_i) >>> shamt);
            alu_slt:  result_o = {31'b0, lt_s};
            alu_sltu: result_o = {31'b0, lt_u};
            default:  result_o = '0;
        endcase
    end

    always_comb begin
        case (cond_i)
            br_eq:   branch_taken_o = eq;
            br_ne:   branch_taken_o = !eq;
            br_lt:   branch_taken_o = lt_s;
            br_ge:   branch_taken_o = !lt_s; // equal counts as taken
            br_ltu:  branch_taken_o = lt_u;
            br_geu:  branch_taken_o = !lt_u;
            default: branch_taken_o = 1'b0;
        endcase
    end

endmodule

// File: logic/reg_file.sv
module reg_file (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [rv_isa_pkg::reg_addr_w-1:0] rs1_addr_i,
    input  logic [rv_isa_pkg::reg_addr_w-1:0] rs2_addr_i,
    output logic [rv_isa_pkg::xlen-1:0]       rs1_data_o,
    output logic [rv_isa_pkg::xlen-1:0]       rs2_data_o,
    input  logic                              wen_i,
    input  logic [rv_isa_pkg::reg_addr_w-1:0] rd_addr_i,
    input  logic [rv_isa_pkg::xlen-1:0]       rd_data_i
);
    import rv_isa_pkg::*;

    localparam int num_regs = 2 ** reg_addr_w;

    logic [xlen-1:0] regs [num_regs];

    // x0 is cleared by reset and never written, so it reads zero
    assign rs1_data_o = regs[rs1_addr_i];
    assign rs2_data_o = regs[rs2_addr_i];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wen_i && rd_addr_i != '0) begin
            regs[rd_addr_i] <= rd_data_i;
        end
    end

    x0_stays_zero: assert property (
        @(posedge clk) disable iff (!rst_n) regs[0] == '0
    );

endmodule

// File: logic/inst_decoder.sv
module inst_decoder (
    input  logic [rv_isa_pkg::xlen-1:0]       inst_i,
    output logic [rv_isa_pkg::reg_addr_w-1:0] rs1_addr_o,
    output logic [rv_isa_pkg::reg_addr_w-1:0] rs2_addr_o,
    output logic [rv_isa_pkg::reg_addr_w-1:0] rd_addr_o,
    output logic [rv_isa_pkg::xlen-1:0]       imm_o,
    output core_ctrl_pkg::alu_op_e            alu_op_o,
    output core_ctrl_pkg::br_cond_e           br_cond_o,
    output core_ctrl_pkg::op1_sel_e           op1_sel_o,
    output core_ctrl_pkg::op2_sel_e           op2_sel_o,
    output core_ctrl_pkg::wb_sel_e            wb_sel_o,
    output logic                              rf_wen_o,
    output logic                              mem_wen_o,
    output logic                              is_jal_o,
    output logic                              is_jalr_o
);
    import rv_isa_pkg::*;
    import core_ctrl_pkg::*;

    opcode_e    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       f7_zero;
    logic       f7_is_alt;
    logic       is_shift;
    logic       reg_ok;
    logic       imm_ok;

    function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt);
        case (f3)
            f3_add_sub: arith_op = alt ? alu_sub : alu_add;
            f3_sll:     arith_op = alu_sll;
            f3_slt:     arith_op = alu_slt;
            f3_sltu:    arith_op = alu_sltu;
            f3_xor:     arith_op = alu_xor;
            f3_srl_sra: arith_op = alt ? alu_sra : alu_srl;
            f3_or:      arith_op = alu_or;
            default:    arith_op = alu_and;
        endcase
    endfunction

    assign opcode     = opcode_e'(inst_i[6:0]);
    assign funct3     = inst_i[14:12];
    assign funct7     = inst_i[31:25];
    assign rs1_addr_o = inst_i[19:15];
    assign rs2_addr_o = inst_i[24:20];
    assign rd_addr_o  = inst_i[11:7];

    assign f7_zero   = (funct7 == 7'b0);
    assign f7_is_alt = (funct7 == f7_alt);
    assign is_shift  = (funct3 == f3_sll) || (funct3 == f3_srl_sra);
    // only add/sub and srl/sra take the alt funct7
    assign reg_ok = f7_zero || (f7_is_alt && (funct3 == f3_add_sub || funct3 == f3_srl_sra));
    assign imm_ok = !is_shift || f7_zero || (f7_is_alt && funct3 == f3_srl_sra);

    always_comb begin
        case (opcode)
            op_imm, op_load, op_jalr: imm_o = {{20{inst_i[31]}}, inst_i[31:20]};
            op_store:  imm_o = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
            op_branch: imm_o = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
            op_jal:    imm_o = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};
            default:   imm_o = '0;
        endcase
    end

    always_comb begin
        // no-op control word unless a known instruction overrides it
        alu_op_o  = alu_add;
        br_cond_o = br_none;
        op1_sel_o = op1_rs1;
        op2_sel_o = op2_rs2;
        wb_sel_o  = wb_alu;
        rf_wen_o  = 1'b0;
        mem_wen_o = 1'b0;
        is_jal_o  = 1'b0;
        is_jalr_o = 1'b0;
        case (opcode)
            op_load: if (funct3 == f3_word) begin
                op2_sel_o = op2_imm;
                wb_sel_o  = wb_mem;
                rf_wen_o  = 1'b1;
            end
            op_store: if (funct3 == f3_word) begin
                op2_sel_o = op2_imm;
                mem_wen_o = 1'b1;
            end
            op_reg: if (reg_ok) begin
                alu_op_o = arith_op(funct3, f7_is_alt);
                rf_wen_o = 1'b1;
            end
            op_imm: if (imm_ok) begin
                alu_op_o  = arith_op(funct3, f7_is_alt && funct3 == f3_srl_sra);
                op2_sel_o = op2_imm;
                rf_wen_o  = 1'b1;
            end
            op_branch: begin
                case (funct3)
                    f3_beq:  br_cond_o = br_eq;
                    f3_bne:  br_cond_o = br_ne;
                    f3_blt:  br_cond_o = br_lt;
                    f3_bge:  br_cond_o = br_ge;
                    f3_bltu: br_cond_o = br_ltu;
                    f3_bgeu: br_cond_o = br_geu;
                    default: br_cond_o = br_none; // 010/011 undefined
                endcase
            end
            op_jal: begin
                op1_sel_o = op1_pc;
                op2_sel_o = op2_imm;
                wb_sel_o  = wb_pc_plus4;
                rf_wen_o  = 1'b1;
                is_jal_o  = 1'b1;
            end
            op_jalr: if (funct3 == f3_jalr) begin
                op2_sel_o = op2_imm;
                wb_sel_o  = wb_pc_plus4;
                rf_wen_o  = 1'b1;
                is_jalr_o = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

// File: logic/core_ctrl_pkg.sv
package core_ctrl_pkg;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_slt,
        alu_sltu
    } alu_op_e;

    // br_none means the instruction is not a branch
    typedef enum logic [2:0] {
        br_none,
        br_eq,
        br_ne,
        br_lt,
        br_ge,
        br_ltu,
        br_geu
    } br_cond_e;

    typedef enum logic {op1_rs1, op1_pc} op1_sel_e;

    typedef enum logic {op2_rs2, op2_imm} op2_sel_e;

    typedef enum logic [1:0] {
        wb_alu,
        wb_mem,
        wb_pc_plus4 // link value for jal / jalr
    } wb_sel_e;

endpackage

// File: logic/rv_isa_pkg.sv
package rv_isa_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    // major opcodes, inst[6:0]
    typedef enum logic [6:0] {
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_reg    = 7'b0110011,
        op_imm    = 7'b0010011,
        op_branch = 7'b1100011,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111
    } opcode_e;

    // alu funct3
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_sltu    = 3'b011;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_srl_sra = 3'b101;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    // branch funct3
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    localparam logic [2:0] f3_word = 3'b010; // lw / sw
    localparam logic [2:0] f3_jalr = 3'b000;

    localparam logic [6:0] f7_alt = 7'b0100000; // sub, sra, srai

endpackage
